// File: Makefile
# Verilator build for the matrix multiply block

VERILATOR ?= verilator
TOP       ?= tb_matmul_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
FLAGS     ?= --assert --timescale 1ns/10ps -j 0

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) logic/matmul_defs.svh
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Output goes to the terminal, pass is decided by the closing message
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

// File: filelist.f
+incdir+logic
logic/matmul_pkg.sv
logic/mac_ctrl_if.sv
logic/row_ram.sv
logic/matmul_ctrl.sv
logic/result_bank.sv
logic/matmul_top.sv
tb/tb_matmul_top.sv

// File: logic/mac_ctrl_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mac_ctrl_if import matmul_pkg::*; ();

  // Accumulate controls, already aligned to operand read data
  logic  acc_en;
  logic  acc_first;

  // C row writeback
  logic  wb_en;
  addr_t wb_row;

  modport ctrl (output acc_en, output acc_first, output wb_en, output wb_row);

  modport mac (input acc_en, input acc_first, input wb_en, input wb_row);

endinterface

`default_nettype wire

// File: logic/matmul_ctrl.sv
`timescale 1ns/10ps
`default_nettype none
`include "matmul_defs.svh"

module matmul_ctrl import matmul_pkg::*; (
  input  logic     clk_mem,
  input  logic     reset,
  input  logic     start_mat_mul,
  input  logic     enable_writing_to_mem,
  input  addr_t    addr_pi,
  output addr_t    op_addr,
  output logic     done_mat_mul,
  mac_ctrl_if.ctrl mac
);

  localparam int STEP_W = $clog2(`MAT_SIZE);
  localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(`MAT_SIZE - 1);

  ctrl_state_t       state;
  logic [STEP_W-1:0] step;
  logic              last_step;
  logic              fetch_valid;
  logic              fetch_first;

  //////////////////////////////////////////////////////////////////////
  // Sequence FSM
  //////////////////////////////////////////////////////////////////////

  assign last_step = (step == LAST_STEP);

  // Step counter runs the operand fetch, then again the C writeback
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      state <= IDLE;
      step  <= '0;
    end else begin
      case (state)
        IDLE: begin
          step <= '0;
          if (start_mat_mul) begin
            state <= FETCH;
          end
        end
        FETCH: begin
          step <= last_step ? '0 : step + 1'b1;
          if (last_step) begin
            state <= DRAIN;
          end
        end
        // Last product still in flight from the RAM
        DRAIN: begin
          state <= WRITE;
        end
        WRITE: begin
          step <= last_step ? '0 : step + 1'b1;
          if (last_step) begin
            state <= FINISH;
          end
        end
        FINISH: begin
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Operand addressing and MAC control
  //////////////////////////////////////////////////////////////////////

  // Host owns the operand RAMs while loading
  assign op_addr = enable_writing_to_mem ? addr_pi : addr_t'(step);

  assign fetch_valid = (state == FETCH);
  assign fetch_first = fetch_valid && (step == '0);

  // One cycle of RAM read latency
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      mac.acc_en    <= 1'b0;
      mac.acc_first <= 1'b0;
    end else begin
      mac.acc_en    <= fetch_valid;
      mac.acc_first <= fetch_first;
    end
  end

  assign mac.wb_en  = (state == WRITE);
  assign mac.wb_row = addr_t'(step);

  assign done_mat_mul = (state == FINISH);

  // Done is a single-cycle strobe per run
  a_done_single : assert property (
    @(posedge clk_mem) disable iff (reset) done_mat_mul |=> !done_mat_mul
  );

  // Accumulation must be complete before writeback starts
  a_acc_wb_excl : assert property (
    @(posedge clk_mem) disable iff (reset) !(mac.acc_en && mac.wb_en)
  );

endmodule

`default_nettype wire

// File: logic/matmul_defs.svh
`ifndef MATMUL_DEFS_SVH
`define MATMUL_DEFS_SVH

// Matrix dimension N
// Also the element count of one row word
`define MAT_SIZE 4

// Operand element width
`define DATA_WIDTH 16

// Result element width, sums wrap modulo 2^32
`define ACC_WIDTH 32

// Row memories
`define ADDR_WIDTH 7
`define MEM_DEPTH 128

`endif

// File: logic/matmul_pkg.sv
`default_nettype none
`include "matmul_defs.svh"

package matmul_pkg;

  // Element types
  typedef logic [`DATA_WIDTH-1:0] elem_t;
  typedef logic [`ACC_WIDTH-1:0]  acc_t;

  // One A column or one B row, lane 0 in the low bits
  typedef elem_t [`MAT_SIZE-1:0] operand_row_t;

  // One C row
  typedef acc_t [`MAT_SIZE-1:0] result_row_t;

  typedef logic [`ADDR_WIDTH-1:0] addr_t;

  // Multiply sequence
  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    DRAIN,
    WRITE,
    FINISH
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: logic/matmul_top.sv
`timescale 1ns/10ps
`default_nettype none

module matmul_top import matmul_pkg::*; (
  input  logic         clk_mem,
  input  logic         reset,
  input  logic         enable_writing_to_mem,
  input  logic         enable_reading_from_mem,
  input  operand_row_t data_pi,
  input  addr_t        addr_pi,
  input  logic         we_a,
  input  logic         we_b,
  input  logic         start_mat_mul,
  output result_row_t  data_from_out_mat,
  output logic         done_mat_mul
);

  addr_t        op_addr;
  operand_row_t a_col;
  operand_row_t b_row;

  mac_ctrl_if mac_if ();

  matmul_ctrl ctrl_i (
    .clk_mem               (clk_mem),
    .reset                 (reset),
    .start_mat_mul         (start_mat_mul),
    .enable_writing_to_mem (enable_writing_to_mem),
    .addr_pi               (addr_pi),
    .op_addr               (op_addr),
    .done_mat_mul          (done_mat_mul),
    .mac                   (mac_if.ctrl)
  );

  // A words hold columns of A
  row_ram #(
    .word_t (operand_row_t)
  ) a_ram (
    .clk_mem (clk_mem),
    .addr    (op_addr),
    .we      (we_a),
    .wdata   (data_pi),
    .rdata   (a_col)
  );

  // B words hold rows of B
  row_ram #(
    .word_t (operand_row_t)
  ) b_ram (
    .clk_mem (clk_mem),
    .addr    (op_addr),
    .we      (we_b),
    .wdata   (data_pi),
    .rdata   (b_row)
  );

  result_bank bank_i (
    .clk_mem                 (clk_mem),
    .reset                   (reset),
    .a_col                   (a_col),
    .b_row                   (b_row),
    .mac                     (mac_if.mac),
    .enable_reading_from_mem (enable_reading_from_mem),
    .addr_pi                 (addr_pi),
    .data_from_out_mat       (data_from_out_mat)
  );

endmodule

`default_nettype wire

// File: logic/result_bank.sv
`timescale 1ns/10ps
`default_nettype none
`include "matmul_defs.svh"

module result_bank import matmul_pkg::*; (
  input  logic         clk_mem,
  input  logic         reset,
  input  operand_row_t a_col,
  input  operand_row_t b_row,
  mac_ctrl_if.mac      mac,
  input  logic         enable_reading_from_mem,
  input  addr_t        addr_pi,
  output result_row_t  data_from_out_mat
);

  localparam int ROW_W = $clog2(`MAT_SIZE);

  // Cell (i,j) lives at acc_rows[i][j]
  result_row_t      acc_rows [`MAT_SIZE];
  acc_t             prod [`MAT_SIZE][`MAT_SIZE];
  logic [ROW_W-1:0] row_sel;
  result_row_t      c_wdata;
  addr_t            c_addr;

  //////////////////////////////////////////////////////////////////////
  // Outer-product MAC array
  //////////////////////////////////////////////////////////////////////

  // Full 32-bit products of A column lane i and B row lane j
  for (genvar i = 0; i < `MAT_SIZE; i++) begin : g_prod_row
    for (genvar j = 0; j < `MAT_SIZE; j++) begin : g_prod_col
      assign prod[i][j] = acc_t'(a_col[i]) * acc_t'(b_row[j]);
    end
  end

  // First step of a run loads, the rest add modulo 2^32
  always_ff @(posedge clk_mem) begin
    if (mac.acc_en) begin
      for (int i = 0; i < `MAT_SIZE; i++) begin
        for (int j = 0; j < `MAT_SIZE; j++) begin
          if (mac.acc_first) begin
            acc_rows[i][j] <= prod[i][j];
          end else begin
            acc_rows[i][j] <= acc_rows[i][j] + prod[i][j];
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // C row memory
  //////////////////////////////////////////////////////////////////////

  assign row_sel = mac.wb_row[ROW_W-1:0];
  assign c_wdata = acc_rows[row_sel];

  // Host readout takes the address port
  assign c_addr = enable_reading_from_mem ? addr_pi : mac.wb_row;

  row_ram #(
    .word_t (result_row_t)
  ) c_ram (
    .clk_mem (clk_mem),
    .addr    (c_addr),
    .we      (mac.wb_en),
    .wdata   (c_wdata),
    .rdata   (data_from_out_mat)
  );

  // A load without an accumulate would leave stale sums in the array
  a_first_in_acc : assert property (
    @(posedge clk_mem) disable iff (reset) mac.acc_first |-> mac.acc_en
  );

endmodule

`default_nettype wire

// File: logic/row_ram.sv
`timescale 1ns/10ps
`default_nettype none
`include "matmul_defs.svh"

module row_ram import matmul_pkg::*; #(
  parameter type word_t = operand_row_t
) (
  input  logic  clk_mem,
  input  addr_t addr,
  input  logic  we,
  input  word_t wdata,
  output word_t rdata
);

  word_t mem [`MEM_DEPTH];

  // Write port
  always_ff @(posedge clk_mem) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  // Registered read, old contents on a same-address write
  always_ff @(posedge clk_mem) begin
    rdata <= mem[addr];
  end

endmodule

`default_nettype wire

// File: tb/tb_matmul_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "matmul_defs.svh"

module tb_matmul_top import matmul_pkg::*; ();

  localparam int N = `MAT_SIZE;
  localparam int NUM_TESTS = 6;

  // Operand patterns
  localparam int PAT_IDENT = 0;
  localparam int PAT_RAND  = 1;
  localparam int PAT_MAX   = 2;
  localparam int PAT_FIXED = 3;

  // Cycle budget: load, start to done, quiet window, readout, margin
  localparam int LOAD_CYCLES   = 2 * N + 2;
  localparam int DONE_LATENCY  = 2 * N + 2;
  localparam int DONE_WAIT     = 4 * N + 8;
  localparam int QUIET_CYCLES  = 2 * N + 4;
  localparam int READ_CYCLES   = N + 2;
  localparam int PER_TEST      = LOAD_CYCLES + DONE_WAIT + QUIET_CYCLES + READ_CYCLES + 16;
  localparam int TIMEOUT_LIMIT = NUM_TESTS * PER_TEST + 20;

  typedef struct {
    string name;
    int    a_pat;
    int    b_pat;
    bit    extra_start;
    bit    stray_write;
  } test_t;

  logic         clk_mem;
  logic         reset;
  logic         enable_writing_to_mem;
  logic         enable_reading_from_mem;
  operand_row_t data_pi;
  addr_t        addr_pi;
  logic         we_a;
  logic         we_b;
  logic         start_mat_mul;
  result_row_t  data_from_out_mat;
  logic         done_mat_mul;

  test_t tests [NUM_TESTS];
  elem_t a_m [N][N];
  elem_t b_m [N][N];
  int    seed = 98;
  int    cycle_count = 0;
  int    tests_passed = 0;
  int    tests_failed = 0;

  matmul_top dut_i (
    .clk_mem                 (clk_mem),
    .reset                   (reset),
    .enable_writing_to_mem   (enable_writing_to_mem),
    .enable_reading_from_mem (enable_reading_from_mem),
    .data_pi                 (data_pi),
    .addr_pi                 (addr_pi),
    .we_a                    (we_a),
    .we_b                    (we_b),
    .start_mat_mul           (start_mat_mul),
    .data_from_out_mat       (data_from_out_mat),
    .done_mat_mul            (done_mat_mul)
  );

  initial begin
    clk_mem = 1'b0;
    forever #2 clk_mem = ~clk_mem;
  end

  // Run limit
  always @(posedge clk_mem) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_LIMIT) begin
      $display("Timeout after %0d cycles, the test sequence did not complete", cycle_count);
      $display("Simulation FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus table and reference model
  //////////////////////////////////////////////////////////////////////

  task automatic fill_table();
    tests[0] = '{"identity_x_random", PAT_IDENT, PAT_RAND,  1'b0, 1'b0};
    tests[1] = '{"random_x_random",   PAT_RAND,  PAT_RAND,  1'b0, 1'b0};
    tests[2] = '{"all_max_wrap",      PAT_MAX,   PAT_MAX,   1'b0, 1'b0};
    tests[3] = '{"extra_start",       PAT_RAND,  PAT_FIXED, 1'b1, 1'b0};
    tests[4] = '{"stray_write",       PAT_FIXED, PAT_RAND,  1'b0, 1'b1};
    tests[5] = '{"fixed_x_identity",  PAT_FIXED, PAT_IDENT, 1'b1, 1'b1};
  endtask

  function automatic elem_t pattern_value(input int pat, input int row, input int col,
                                          input bit is_a);
    case (pat)
      PAT_IDENT: return (row == col) ? elem_t'(1) : elem_t'(0);
      PAT_RAND:  return elem_t'($random(seed));
      PAT_MAX:   return elem_t'(16'hFFFF);
      default:   return elem_t'((row * N + col + 1) * (is_a ? 32'h0123 : 32'h0457));
    endcase
  endfunction

  // C[i][j] = sum over k of A[i][k] * B[k][j], low 32 bits kept
  function automatic result_row_t expected_row(input int i);
    result_row_t row;
    logic [63:0] sum;
    for (int j = 0; j < N; j++) begin
      sum = 64'd0;
      for (int k = 0; k < N; k++) begin
        sum = sum + 64'(a_m[i][k]) * 64'(b_m[k][j]);
      end
      row[j] = sum[31:0];
    end
    return row;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Host port tasks, all start and end on a falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic write_word(input bit to_a, input int addr, input operand_row_t word);
    enable_writing_to_mem = 1'b1;
    addr_pi = addr_t'(addr);
    data_pi = word;
    we_a = to_a;
    we_b = !to_a;
    @(negedge clk_mem);
    we_a = 1'b0;
    we_b = 1'b0;
    enable_writing_to_mem = 1'b0;
  endtask

  task automatic load_operands(input test_t t);
    operand_row_t word;
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        a_m[i][j] = pattern_value(t.a_pat, i, j, 1'b1);
        b_m[i][j] = pattern_value(t.b_pat, i, j, 1'b0);
      end
    end
    // A words are columns, B words are rows
    for (int k = 0; k < N; k++) begin
      for (int l = 0; l < N; l++) begin
        word[l] = a_m[l][k];
      end
      write_word(1'b1, k, word);
    end
    for (int k = 0; k < N; k++) begin
      for (int l = 0; l < N; l++) begin
        word[l] = b_m[k][l];
      end
      write_word(1'b0, k, word);
    end
    if (t.stray_write) begin
      write_word(1'b1, N + 5, {N{16'hA5C3}});
      write_word(1'b0, N + 5, {N{16'h3C5A}});
    end
  endtask

  task automatic run_multiply(input bit extra, output bit got_done, output int lat,
                              output int extra_dones);
    got_done = 1'b0;
    lat = 0;
    extra_dones = 0;
    start_mat_mul = 1'b1;
    while (!got_done && lat < DONE_WAIT) begin
      @(negedge clk_mem);
      lat = lat + 1;
      // Second start lands mid-run
      start_mat_mul = extra && (lat == 3);
      if (done_mat_mul) begin
        got_done = 1'b1;
      end
    end
    start_mat_mul = 1'b0;
    if (got_done) begin
      repeat (QUIET_CYCLES) begin
        @(negedge clk_mem);
        if (done_mat_mul) begin
          extra_dones = extra_dones + 1;
        end
      end
    end
  endtask

  task automatic read_and_check(input string name, output int errors);
    result_row_t exp;
    errors = 0;
    enable_reading_from_mem = 1'b1;
    for (int i = 0; i < N; i++) begin
      addr_pi = addr_t'(i);
      @(negedge clk_mem);
      exp = expected_row(i);
      if (data_from_out_mat !== exp) begin
        $display("[ERROR] %s row %0d: expected %h, actual %h", name, i, exp,
                 data_from_out_mat);
        errors = errors + 1;
      end
    end
    enable_reading_from_mem = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    bit got_done;
    int lat;
    int extra_dones;
    int errors;

    reset = 1'b1;
    enable_writing_to_mem = 1'b0;
    enable_reading_from_mem = 1'b0;
    data_pi = '0;
    addr_pi = '0;
    we_a = 1'b0;
    we_b = 1'b0;
    start_mat_mul = 1'b0;
    fill_table();

    repeat (5) @(posedge clk_mem);
    @(negedge clk_mem);
    reset = 1'b0;
    @(negedge clk_mem);

    for (int t = 0; t < NUM_TESTS; t++) begin
      errors = 0;
      load_operands(tests[t]);
      run_multiply(tests[t].extra_start, got_done, lat, extra_dones);
      if (!got_done) begin
        $display("%s: done_mat_mul never arrived within %0d cycles", tests[t].name,
                 DONE_WAIT);
        errors = errors + 1;
      end else begin
        if (lat != DONE_LATENCY) begin
          $display("[ERROR] %s latency: expected %0d, actual %0d", tests[t].name,
                   DONE_LATENCY, lat);
          errors = errors + 1;
        end
        if (extra_dones != 0) begin
          $display("%s: %0d extra done pulses after the first one", tests[t].name,
                   extra_dones);
          errors = errors + 1;
        end
        read_and_check(tests[t].name, lat);
        errors = errors + lat;
      end
      if (errors == 0) begin
        $display("[PASS] %s", tests[t].name);
        tests_passed = tests_passed + 1;
      end else begin
        $display("[FAIL] %s (%0d errors)", tests[t].name, errors);
        tests_failed = tests_failed + 1;
      end
    end

    $display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
